// File: Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_mem_stage
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed
FAIL_MSG   := Regression failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/mem_checker.sv
`timescale 1ns/1ps

module mem_checker #(
   parameter int ADDR_W = 12
) (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  mem_pkg::mem_req_t i_req,
   input  logic [31:0]       i_rdata,
   input  logic              i_rvalid,
   input  logic              i_misalign,
   input  logic              i_test_end,
   input  int                i_test_num,
   output int                o_checks,
   output int                o_errors
);
   import mem_pkg::*;

   localparam int RAM_BYTES = 2**(ADDR_W-1);   // Region bit removed

   // Expected output slot
   typedef struct packed {
      logic [31:0] rdata;
      logic        rvalid;
      logic        misalign;
   } result_t;

   logic [7:0]  ram_m [RAM_BYTES];   // Byte model of the RAM
   logic [31:0] io_m  [NUM_IO_REGS];
   result_t     pipe [$];            // Requests still inside the DUT
   result_t     nxt;
   int          n_checks;
   int          n_errors;
   int          t_checks;            // Per test counts
   int          t_errors;

   assign o_checks = n_checks;
   assign o_errors = n_errors;

   initial begin
      for (int i = 0; i < RAM_BYTES; i++) begin
         ram_m[i] = 8'h00;
      end
      for (int i = 0; i < NUM_IO_REGS; i++) begin
         io_m[i] = 32'h0;
      end
      n_checks = 0;
      n_errors = 0;
      t_checks = 0;
      t_errors = 0;
   end

   function automatic logic fits(input mem_size_e sz, input logic [1:0] off);
      if (sz == SIZE_HALF) return (off[0] == 1'b0);
      if (sz == SIZE_WORD) return (off == 2'b00);
      return 1'b1;
   endfunction

   // Predict one request from the old word before applying its store
   task automatic model_step(input mem_req_t r, output result_t res);
      logic [ADDR_W-1:0] a;
      logic [1:0]        off;
      logic              act;
      logic              ok;
      logic [31:0]       old_w;
      logic [7:0]        b;
      logic [15:0]       h;
      int                base;
      int                ri;
      int                nb;
      a    = r.addr[ADDR_W-1:0];
      off  = a[1:0];
      base = int'(a[ADDR_W-2:2]) * 4;
      ri   = int'(a[ADDR_W-2:2]) % NUM_IO_REGS;   // Bank repeats every four words
      act  = (r.rd_size != SIZE_NONE) || (r.wr_size != SIZE_NONE);
      ok   = fits(r.rd_size, off) && fits(r.wr_size, off);
      if (a[ADDR_W-1]) old_w = io_m[ri];
      else old_w = {ram_m[base+3], ram_m[base+2], ram_m[base+1], ram_m[base]};
      res          = '0;
      res.misalign = act && !ok;
      if (ok && r.rd_size != SIZE_NONE) begin
         res.rvalid = 1'b1;
         b = old_w[8*off +: 8];
         h = old_w[8*off +: 16];
         case (r.rd_size)
            SIZE_BYTE: begin
               res.rdata = {24'h0, b};
               if (r.sign_ext && b[7]) res.rdata[31:8] = '1;
            end
            SIZE_HALF: begin
               res.rdata = {16'h0, h};
               if (r.sign_ext && h[15]) res.rdata[31:16] = '1;
            end
            default: res.rdata = old_w;
         endcase
      end
      if (ok && r.wr_size != SIZE_NONE) begin
         nb = (r.wr_size == SIZE_WORD) ? 4 : ((r.wr_size == SIZE_HALF) ? 2 : 1);
         for (int k = 0; k < nb; k++) begin
            b = r.wdata[8*k +: 8];   // Store data is right justified
            if (!a[ADDR_W-1]) begin
               ram_m[base + off + k] = b;
            end else if (ri == NUM_IO_REGS - 1) begin
               io_m[ri][8*(off+k) +: 8] = io_m[ri][8*(off+k) +: 8] | b;   // Sticky bits
            end else begin
               io_m[ri][8*(off+k) +: 8] = b;
            end
         end
      end
   endtask

   task automatic flag_mismatch(input string msg);
      n_errors++;
      t_errors++;
      $display("ERROR @%0t: test %0d %s", $time, i_test_num, msg);
   endtask

   task automatic compare(input result_t exp);
      n_checks++;
      t_checks++;
      if (i_rvalid !== exp.rvalid) begin
         flag_mismatch($sformatf("rvalid exp %0b got %0b", exp.rvalid, i_rvalid));
      end
      if (i_misalign !== exp.misalign) begin
         flag_mismatch($sformatf("misalign exp %0b got %0b", exp.misalign, i_misalign));
      end
      if (i_rdata !== exp.rdata) begin
         flag_mismatch($sformatf("rdata exp %h got %h", exp.rdata, i_rdata));
      end
   endtask

   // Sample on the falling edge where inputs and outputs have settled
   always @(negedge i_clk) begin
      if (!i_rst_n) begin
         for (int i = 0; i < NUM_IO_REGS; i++) begin
            io_m[i] = 32'h0;
         end
         pipe.delete();
      end else begin
         if (pipe.size() >= 2) compare(pipe.pop_front());   // Two edges of latency
         model_step(i_req, nxt);
         pipe.push_back(nxt);
         if (i_test_end) begin
            $display("Test %0d finished: %0d cycles checked, %0d mismatches",
                     i_test_num, t_checks, t_errors);
            t_checks = 0;
            t_errors = 0;
         end
      end
   end

endmodule

// File: dv/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
   import mem_pkg::*;

   localparam int ADDR_W    = 12;
   localparam int N_WORDS   = 24;   // Word write/read pairs
   localparam int N_MERGE   = 16;   // Groups of four requests
   localparam int N_EXT     = 8;    // Words of 13 requests each
   localparam int N_MIS     = 12;   // Groups of three requests
   localparam int N_IO      = 40;   // Upper bound of the I/O test
   localparam int N_RAND    = 600;
   localparam int N_TESTS   = 6;
   localparam int TOTAL_REQ = 2*N_WORDS + 4*N_MERGE + 13*N_EXT + 3*N_MIS + N_IO + N_RAND
                              + 4*N_TESTS;                 // Drain and end cycles per test
   localparam int WATCHDOG_NS = (TOTAL_REQ + 200) * 10;   // Reset plus margin

   logic        clk;
   logic        rst_n;
   mem_req_t    req;
   logic [31:0] rdata;
   logic        rvalid;
   logic        misalign;
   logic        test_end;   // One cycle pulse at the end of each test
   int          test_num;   // Test now running
   int          n_checks;
   int          n_errors;
   integer      seed;

   mem_stage_top #(
      .ADDR_W (ADDR_W)
   ) uut (
      .i_clk      (clk),
      .i_rst_n    (rst_n),
      .i_req      (req),
      .o_rdata    (rdata),
      .o_rvalid   (rvalid),
      .o_misalign (misalign)
   );

   mem_checker #(
      .ADDR_W (ADDR_W)
   ) u_chk (
      .i_clk      (clk),
      .i_rst_n    (rst_n),
      .i_req      (req),
      .i_rdata    (rdata),
      .i_rvalid   (rvalid),
      .i_misalign (misalign),
      .i_test_end (test_end),
      .i_test_num (test_num),
      .o_checks   (n_checks),
      .o_errors   (n_errors)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Word index above the offset and the region in the top bit
   function automatic logic [31:0] make_addr(input logic region, input logic [31:0] widx,
                                             input logic [1:0] off);
      logic [31:0] a;
      a = (widx << 2) | 32'(off);
      a[ADDR_W-1] = region;
      return a;
   endfunction

   // Drive one request for one cycle
   task automatic send(input mem_size_e rd, input mem_size_e wr, input logic sx,
                       input logic [31:0] addr, input logic [31:0] wdata);
      req.rd_size  = rd;
      req.wr_size  = wr;
      req.sign_ext = sx;
      req.addr     = addr;
      req.wdata    = wdata;
      @(posedge clk);
      #1;
   endtask

   task automatic finish_test(input int n);
      repeat (3) send(SIZE_NONE, SIZE_NONE, 1'b0, 32'h0, 32'h0);  // Let the pipe drain
      test_end = 1'b1;
      @(posedge clk);
      #1;
      test_end = 1'b0;
      test_num = n + 1;
   endtask

   task automatic word_round_trip();
      logic [31:0] idx [N_WORDS];
      for (int i = 0; i < N_WORDS; i++) begin
         idx[i] = $random(seed);
         send(SIZE_NONE, SIZE_WORD, 1'b0, make_addr(1'b0, idx[i], 2'd0), $random(seed));
      end
      for (int i = 0; i < N_WORDS; i++) begin
         send(SIZE_WORD, SIZE_NONE, 1'b0, make_addr(1'b0, idx[i], 2'd0), 32'h0);
      end
      finish_test(1);
   endtask

   task automatic lane_merge();
      logic [31:0] w;
      logic [31:0] r;
      for (int i = 0; i < N_MERGE; i++) begin
         w = $random(seed);
         r = $random(seed);
         send(SIZE_NONE, SIZE_WORD, 1'b0, make_addr(1'b0, w, 2'd0), $random(seed));
         send(SIZE_NONE, SIZE_BYTE, 1'b0, make_addr(1'b0, w, r[1:0]), $random(seed));
         send(SIZE_NONE, SIZE_HALF, 1'b0, make_addr(1'b0, w, {r[2], 1'b0}), $random(seed));
         send(SIZE_WORD, SIZE_NONE, 1'b0, make_addr(1'b0, w, 2'd0), 32'h0);  // Merged word
      end
      finish_test(2);
   endtask

   task automatic load_extend();
      logic [31:0] w;
      logic [31:0] d;
      for (int i = 0; i < N_EXT; i++) begin
         w = $random(seed);
         d = $random(seed);
         d = (i % 2 == 0) ? (d | 32'h8080_8080) : (d & 32'h7f7f_7f7f);  // Both sign cases
         send(SIZE_NONE, SIZE_WORD, 1'b0, make_addr(1'b0, w, 2'd0), d);
         for (int off = 0; off < 4; off++) begin
            for (int sx = 0; sx < 2; sx++) begin
               send(SIZE_BYTE, SIZE_NONE, 1'(sx), make_addr(1'b0, w, 2'(off)), 32'h0);
            end
         end
         for (int hw = 0; hw < 2; hw++) begin
            for (int sx = 0; sx < 2; sx++) begin
               send(SIZE_HALF, SIZE_NONE, 1'(sx), make_addr(1'b0, w, {1'(hw), 1'b0}), 32'h0);
            end
         end
      end
      finish_test(3);
   endtask

   task automatic misaligned_access();
      logic [31:0] w;
      logic [31:0] r;
      logic [1:0]  odd;
      logic [1:0]  nz;
      logic        reg_bank;
      for (int i = 0; i < N_MIS; i++) begin
         w        = $random(seed);
         r        = $random(seed);
         odd      = {r[1], 1'b1};
         nz       = (r[1:0] == 2'b00) ? 2'b01 : r[1:0];
         reg_bank = (i >= N_MIS - 4);   // Last few go to the I/O bank
         send(SIZE_NONE, SIZE_WORD, 1'b0, make_addr(reg_bank, w, 2'd0), $random(seed));
         case (i % 4)
            0:       send(SIZE_NONE, SIZE_HALF, 1'b0, make_addr(reg_bank, w, odd), r);
            1:       send(SIZE_NONE, SIZE_WORD, 1'b0, make_addr(reg_bank, w, nz), r);
            2:       send(SIZE_HALF, SIZE_NONE, 1'b1, make_addr(reg_bank, w, odd), 32'h0);
            default: send(SIZE_WORD, SIZE_BYTE, 1'b0, make_addr(reg_bank, w, nz), r);
         endcase
         send(SIZE_WORD, SIZE_NONE, 1'b0, make_addr(reg_bank, w, 2'd0), 32'h0);  // Unchanged
      end
      finish_test(4);
   endtask

   task automatic io_bank();
      logic [31:0] w;
      logic [31:0] r;
      for (int n = 0; n < 3; n++) begin
         r = $random(seed);
         w = {r[29:0], 2'(n)};   // Junk above the register index
         send(SIZE_NONE, SIZE_WORD, 1'b0, make_addr(1'b1, w, 2'd0), $random(seed));
         send(SIZE_WORD, SIZE_NONE, 1'b0, make_addr(1'b1, w, 2'd0), 32'h0);
         send(SIZE_NONE, SIZE_BYTE, 1'b0, make_addr(1'b1, w, r[31:30]), $random(seed));
         send(SIZE_WORD, SIZE_NONE, 1'b0, make_addr(1'b1, w, 2'd0), 32'h0);
         send(SIZE_NONE, SIZE_HALF, 1'b0, make_addr(1'b1, w, {r[5], 1'b0}), $random(seed));
         send(SIZE_WORD, SIZE_NONE, 1'b0, make_addr(1'b1, w, 2'd0), 32'h0);
      end
      // Flag register only ever gains bits
      send(SIZE_NONE, SIZE_WORD, 1'b0, make_addr(1'b1, 32'd3, 2'd0), 32'h0000_00f0);
      send(SIZE_NONE, SIZE_BYTE, 1'b0, make_addr(1'b1, 32'd3, 2'd0), 32'h0000_000f);
      send(SIZE_NONE, SIZE_HALF, 1'b0, make_addr(1'b1, 32'd3, 2'd2), 32'h0000_1200);
      send(SIZE_WORD, SIZE_NONE, 1'b0, make_addr(1'b1, 32'd3, 2'd0), 32'h0);
      send(SIZE_NONE, SIZE_WORD, 1'b0, make_addr(1'b1, 32'd3, 2'd0), 32'h0);  // Clears nothing
      send(SIZE_WORD, SIZE_NONE, 1'b0, make_addr(1'b1, 32'd3, 2'd0), 32'h0);
      // Read and write of one word in one cycle returns the old value
      send(SIZE_WORD, SIZE_WORD, 1'b0, make_addr(1'b1, 32'd1, 2'd0), $random(seed));
      send(SIZE_WORD, SIZE_NONE, 1'b0, make_addr(1'b1, 32'd1, 2'd0), 32'h0);
      w = $random(seed);
      send(SIZE_WORD, SIZE_WORD, 1'b0, make_addr(1'b0, w, 2'd0), $random(seed));
      send(SIZE_WORD, SIZE_NONE, 1'b0, make_addr(1'b0, w, 2'd0), 32'h0);
      send(SIZE_BYTE, SIZE_NONE, 1'b1, make_addr(1'b1, 32'd3, 2'd0), 32'h0);
      finish_test(5);
   endtask

   task automatic random_mix();
      logic [31:0] r0;
      logic [31:0] a;
      mem_size_e   rd;
      mem_size_e   wr;
      for (int i = 0; i < N_RAND; i++) begin
         r0 = $random(seed);
         a  = $random(seed);   // Upper address bits stay random
         rd = mem_size_e'(r0[1:0]);
         wr = mem_size_e'(r0[3:2]);
         if (r0[7:4] != 4'h0) begin   // Mostly aligned with a few left misaligned
            if (rd == SIZE_WORD || wr == SIZE_WORD) begin
               a[1:0] = 2'b00;
            end else if (rd == SIZE_HALF || wr == SIZE_HALF) begin
               a[0] = 1'b0;
            end
         end
         if (r0[8]) a[ADDR_W-2:7] = '0;   // Crowd RAM traffic onto 32 words
         send(rd, wr, r0[9], a, $random(seed));
      end
      finish_test(6);
   endtask

   initial begin
      seed     = 92351;
      rst_n    = 1'b0;
      req      = '0;
      test_end = 1'b0;
      test_num = 1;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      word_round_trip();
      lane_merge();
      load_extend();
      misaligned_access();
      io_bank();
      random_mix();
      $display("Summary: %0d tests, %0d cycles checked, %0d mismatches",
               N_TESTS, n_checks, n_errors);
      if (n_errors == 0 && n_checks > 0) begin
         $display("Regression passed");
      end else begin
         if (n_checks == 0) $display("No DUT output was ever compared");
         $display("Regression failed");
      end
      $finish;
   end

   // Watchdog against a stuck run
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns and the tests did not finish", WATCHDOG_NS);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: sim.f
src/mem_pkg.sv
src/mem_access_decode.sv
src/data_memory.sv
src/io_regs.sv
src/load_align.sv
src/mem_stage_top.sv
dv/mem_checker.sv
dv/tb_mem_stage.sv

// File: src/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
   parameter int ADDR_W = 12  // Byte address width incl. region bit
) (
   input  logic               i_clk,
   input  logic               i_sel,
   input  mem_pkg::lane_req_t i_lane,
   output logic [31:0]        o_rdata
);

   localparam int IDX_W = ADDR_W - 3;   // Region bit and byte offset removed
   localparam int DEPTH = 2**IDX_W;     // Words in the RAM

   logic [IDX_W-1:0] idx;
   logic             rd_en;

   assign idx   = i_lane.word_addr[IDX_W-1:0];
   assign rd_en = i_sel & i_lane.rd;

   // One byte column per lane
   for (genvar g = 0; g < 4; g++) begin : g_col
      logic [7:0] col [DEPTH];

      // Clear the column at start of simulation
      initial begin
         for (int k = 0; k < DEPTH; k++) begin
            col[k] = 8'h00;
         end
      end

      // Column write, gated by its lane enable
      always_ff @(posedge i_clk) begin
         if (i_sel && i_lane.be[g]) begin
            col[idx] <= i_lane.lane_data[8*g +: 8];
         end
      end

      // Read first, holds value when not reading
      always_ff @(posedge i_clk) begin
         if (rd_en) begin
            o_rdata[8*g +: 8] <= col[idx];  // Old data on a same-word write
         end
      end
   end

endmodule

// File: src/io_regs.sv
`timescale 1ns/1ps

module io_regs (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  logic               i_sel,
   input  mem_pkg::lane_req_t i_lane,
   output logic [31:0]        o_rdata
);
   import mem_pkg::*;

   localparam int IDX_W  = $clog2(NUM_IO_REGS);
   localparam int STICKY = NUM_IO_REGS - 1;   // Last register ORs in writes

   logic [31:0]      regs [NUM_IO_REGS];
   logic [IDX_W-1:0] idx;
   logic             is_sticky;

   assign idx       = i_lane.word_addr[IDX_W-1:0];  // Word index modulo bank size
   assign is_sticky = (idx == IDX_W'(STICKY));

   // Byte lane writes, sticky register only sets bits
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int r = 0; r < NUM_IO_REGS; r++) begin
            regs[r] <= '0;
         end
      end else if (i_sel) begin
         for (int b = 0; b < 4; b++) begin
            if (i_lane.be[b]) begin
               if (is_sticky) begin
                  regs[idx][8*b +: 8] <= regs[idx][8*b +: 8] | i_lane.lane_data[8*b +: 8];
               end else begin
                  regs[idx][8*b +: 8] <= i_lane.lane_data[8*b +: 8];
               end
            end
         end
      end
   end

   // Registered read, sees the value before this cycle's write
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rdata <= '0;
      end else if (i_sel && i_lane.rd) begin
         o_rdata <= regs[idx];
      end
   end

endmodule

// File: src/load_align.sv
`timescale 1ns/1ps

module load_align (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  mem_pkg::load_ctl_t i_ctl,
   input  logic [31:0]        i_ram_data,
   input  logic [31:0]        i_io_data,
   output logic [31:0]        o_rdata,
   output logic               o_rvalid,
   output logic               o_misalign
);
   import mem_pkg::*;

   mem_word_u   word;
   logic [7:0]  byte_sel;
   logic [15:0] half_sel;
   logic [31:0] ext_data;

   // Region word picked by the delayed region bit
   assign word = i_ctl.region ? i_io_data : i_ram_data;

   assign byte_sel = word.b[i_ctl.offset];      // Addressed byte lane
   assign half_sel = word.h[i_ctl.offset[1]];   // Aligned halfword, bit 0 is clear

   // Zero or sign extension to 32 bits
   always_comb begin
      case (i_ctl.rd_size)
         SIZE_BYTE: ext_data = {{24{i_ctl.sign_ext & byte_sel[7]}}, byte_sel};
         SIZE_HALF: ext_data = {{16{i_ctl.sign_ext & half_sel[15]}}, half_sel};
         SIZE_WORD: ext_data = word;
         default:   ext_data = '0;
      endcase
   end

   // Result slot, data zero unless an accepted load
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rdata    <= '0;
         o_rvalid   <= 1'b0;
         o_misalign <= 1'b0;
      end else begin
         o_rdata    <= i_ctl.valid ? ext_data : 32'h0;
         o_rvalid   <= i_ctl.valid;      // One pulse per accepted load
         o_misalign <= i_ctl.misalign;   // Same slot as the would-be result
      end
   end

endmodule

// File: src/mem_access_decode.sv
`timescale 1ns/1ps

module mem_access_decode #(
   parameter int ADDR_W = 12  // Byte address width
) (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  mem_pkg::mem_req_t  i_req,
   output mem_pkg::lane_req_t o_lane,
   output logic               o_ram_sel,
   output logic               o_io_sel,
   output mem_pkg::load_ctl_t o_load_ctl
);
   import mem_pkg::*;

   logic [1:0] offset;
   logic       region;
   logic       rd_act;
   logic       wr_act;
   logic       aligned;
   load_ctl_t  ctl_d;

   // Halfword needs even address, word needs bits 1:0 clear
   function automatic logic size_aligned(input mem_size_e sz, input logic [1:0] off);
      case (sz)
         SIZE_HALF: return ~off[0];
         SIZE_WORD: return (off == 2'b00);
         default:   return 1'b1;  // Bytes and no access are always fine
      endcase
   endfunction

   assign offset  = i_req.addr[1:0];
   assign region  = i_req.addr[ADDR_W-1];        // Top address bit picks the region
   assign rd_act  = (i_req.rd_size != SIZE_NONE);
   assign wr_act  = (i_req.wr_size != SIZE_NONE);
   assign aligned = size_aligned(i_req.rd_size, offset) & size_aligned(i_req.wr_size, offset);

   // Word index below the region bit
   assign o_lane.word_addr = 32'(i_req.addr[ADDR_W-2:2]);
   assign o_lane.rd        = rd_act & aligned;   // Misaligned load reads nothing

   always_comb begin
      o_lane.be        = 4'b0000;
      o_lane.lane_data = i_req.wdata;
      if (aligned) begin
         case (i_req.wr_size)
            SIZE_BYTE: begin
               o_lane.be        = 4'b0001 << offset;
               o_lane.lane_data = {4{i_req.wdata[7:0]}};   // Byte copied to every lane
            end
            SIZE_HALF: begin
               o_lane.be        = 4'b0011 << offset;
               o_lane.lane_data = {2{i_req.wdata[15:0]}};  // Halfword on both halves
            end
            SIZE_WORD: o_lane.be = 4'b1111;
            default:   o_lane.be = 4'b0000;
         endcase
      end
   end

   // Region enables, only for active requests
   assign o_ram_sel = (rd_act | wr_act) & ~region;
   assign o_io_sel  = (rd_act | wr_act) & region;

   always_comb begin
      ctl_d.region   = region;
      ctl_d.offset   = offset;
      ctl_d.rd_size  = i_req.rd_size;
      ctl_d.sign_ext = i_req.sign_ext;
      ctl_d.valid    = rd_act & aligned;                // Accepted load
      ctl_d.misalign = (rd_act | wr_act) & ~aligned;    // Any rejected request
   end

   // Load control lines up with the registered region reads
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_load_ctl <= '0;
      end else begin
         o_load_ctl <= ctl_d;
      end
   end

endmodule

// File: src/mem_pkg.sv
package mem_pkg;

   // Access size code, shared by read and write size fields
   typedef enum logic [1:0] {
      SIZE_NONE = 2'd0,  // No access
      SIZE_BYTE = 2'd1,
      SIZE_HALF = 2'd2,
      SIZE_WORD = 2'd3
   } mem_size_e;

   // Number of registers in the I/O bank
   localparam int NUM_IO_REGS = 4;

   // One request per cycle from the execute side
   typedef struct packed {
      mem_size_e   rd_size;   // Load size, SIZE_NONE for no load
      mem_size_e   wr_size;   // Store size, SIZE_NONE for no store
      logic        sign_ext;  // Sign extend byte and halfword loads
      logic [31:0] addr;      // Byte address, low ADDR_W bits decoded
      logic [31:0] wdata;     // Store data, right justified
   } mem_req_t;

   // Decoded access sent to both regions
   typedef struct packed {
      logic [31:0] word_addr;  // Word index inside the region
      logic [3:0]  be;         // Byte write mask
      logic        rd;         // Read strobe
      logic [31:0] lane_data;  // Store data on its byte lanes
   } lane_req_t;

   // Load control, one cycle behind the request
   typedef struct packed {
      logic        region;    // 0 RAM, 1 I/O bank
      logic [1:0]  offset;    // Byte offset in the word
      mem_size_e   rd_size;
      logic        sign_ext;
      logic        valid;     // Accepted read in flight
      logic        misalign;  // Request was rejected
   } load_ctl_t;

   // Two views of one read word
   typedef union packed {
      logic [3:0][7:0]  b;  // Byte lanes, b[0] at the lowest address
      logic [1:0][15:0] h;  // Halfwords, h[0] at the lower address
   } mem_word_u;

endpackage

// File: src/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top #(
   parameter int ADDR_W = 12  // Byte address width, top bit is the region
) (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  mem_pkg::mem_req_t i_req,
   output logic [31:0]       o_rdata,
   output logic              o_rvalid,
   output logic              o_misalign
);
   import mem_pkg::*;

   lane_req_t   lane;        // Shared by both regions
   logic        ram_sel;
   logic        io_sel;
   load_ctl_t   load_ctl;    // Registered with the region reads
   logic [31:0] ram_rdata;
   logic [31:0] io_rdata;

   // Alignment, lanes and region select
   mem_access_decode #(
      .ADDR_W (ADDR_W)
   ) u_decode (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_req      (i_req),
      .o_lane     (lane),
      .o_ram_sel  (ram_sel),
      .o_io_sel   (io_sel),
      .o_load_ctl (load_ctl)
   );

   // Data RAM, region 0
   data_memory #(
      .ADDR_W (ADDR_W)
   ) u_ram (
      .i_clk   (i_clk),
      .i_sel   (ram_sel),
      .i_lane  (lane),
      .o_rdata (ram_rdata)
   );

   // I/O bank, region 1
   io_regs u_io (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_sel   (io_sel),
      .i_lane  (lane),
      .o_rdata (io_rdata)
   );

   // Lane pick, extension and result register
   load_align u_load (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_ctl      (load_ctl),
      .i_ram_data (ram_rdata),
      .i_io_data  (io_rdata),
      .o_rdata    (o_rdata),
      .o_rvalid   (o_rvalid),
      .o_misalign (o_misalign)
   );

endmodule
